/* filelist.f */
hdl/fractal_pkg.sv
hdl/iter_color_map.sv
hdl/frame_write_counter.sv
hdl/frame_memory.sv
hdl/scan_timing_fsm.sv
hdl/video_output.sv
hdl/fractal_frame_top.sv
sim/fractal_frame_checker.sv
sim/fractal_frame_tb.sv

/* Makefile */
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = fractal_frame_tb
FILELIST   = filelist.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/fractal_frame_tb.sv */
module fractal_frame_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import fractal_pkg::*;

	//////////////////////////////////////////////////
	// run constants
	//////////////////////////////////////////////////

	localparam int HALF_PERIOD   = 20;
	localparam int RESET_CYCLES  = 16;
	localparam int SEED          = 32'h89876914;
	localparam iter_count_t MAX_ITER = 32'd1000;
	localparam int LINE_CYCLES   = H_ACTIVE_PIXELS + H_FRONT_LEN + H_PULSE_LEN + H_BACK_LEN;
	localparam int FRAME_LINES   = V_ACTIVE_LINES + V_FRONT_LEN + V_PULSE_LEN + V_BACK_LEN;
	localparam int FRAME_CYCLES  = LINE_CYCLES * FRAME_LINES;
	// valid is high about 3 cycles in 4
	localparam int WRITE_TIMEOUT = 4 * FRAME_PIXELS;
	localparam int DONE_TIMEOUT  = 8;
	localparam int SCAN_TIMEOUT  = 3 * FRAME_CYCLES;
	localparam int EXTRA_OFFERS  = 1000;

	logic         M10k_pll;
	logic         reset;
	iter_count_t  max_iterations;
	iter_count_t  iter_count;
	logic         iter_valid;
	logic         iter_ready;
	logic         frame_done;
	vga_channel_t vga_red;
	vga_channel_t vga_green;
	vga_channel_t vga_blue;
	logic         vga_hsync;
	logic         vga_vsync;
	logic         vga_blank_n;

	int seed;
	int accepted;
	// expected colour per raster index
	pixel_color_t color_model[$];
	// per test error counts
	int err_reset;
	int err_handshake;
	int err_color;
	int err_bank;
	int err_timing;
	int err_frame2;
	int tests_run;
	int tests_failed;

	fractal_frame_top i_dut (
		.M10k_pll       (M10k_pll),
		.reset          (reset),
		.max_iterations (max_iterations),
		.iter_count     (iter_count),
		.iter_valid     (iter_valid),
		.iter_ready     (iter_ready),
		.frame_done     (frame_done),
		.vga_red        (vga_red),
		.vga_green      (vga_green),
		.vga_blue       (vga_blue),
		.vga_hsync      (vga_hsync),
		.vga_vsync      (vga_vsync),
		.vga_blank_n    (vga_blank_n)
	);

	initial begin
		M10k_pll = 1'b0;
		forever #(HALF_PERIOD) M10k_pll = ~M10k_pll;
	end

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	// first band from the top whose threshold is reached
	function automatic pixel_color_t expected_color(input iter_count_t count);
		for (int k = 0; k < PALETTE_BANDS - 1; k++) begin
			if (count >= (MAX_ITER >> k)) begin
				return PALETTE[k];
			end
		end
		return PALETTE[PALETTE_BANDS - 1];
	endfunction

	// right shift of a wide range reaches every band
	task automatic next_count(output iter_count_t value);
		int unsigned span;
		int unsigned shift;
		span  = $unsigned($random(seed)) % (2 * MAX_ITER);
		shift = $unsigned($random(seed)) % 11;
		value = iter_count_t'(span >> shift);
	endtask

	function automatic logic is_bank_edge(input int idx);
		for (int k = 1; k < NUM_BANKS; k++) begin
			if (idx == k * BANK_WORDS || idx == k * BANK_WORDS - 1) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	//////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////

	task automatic check_color(input string name, input pixel_color_t got,
			input pixel_color_t exp, inout int errs);
		if (got !== exp) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			errs++;
		end
	endtask

	task automatic check_channel(input string name, input vga_channel_t got,
			input vga_channel_t exp, inout int errs);
		if (got !== exp) begin
			$display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
			errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp,
			inout int errs);
		if (got !== exp) begin
			$display("ERROR %0t %s got %b expected %b", $time, name, got, exp);
			errs++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp,
			inout int errs);
		if (got != exp) begin
			$display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
			errs++;
		end
	endtask

	// channels hold the colour bits at the top
	task automatic check_rgb(input pixel_color_t exp_c, inout int errs);
		check_channel("vga_red", vga_red, {exp_c[7:5], 5'd0}, errs);
		check_channel("vga_green", vga_green, {exp_c[4:2], 5'd0}, errs);
		check_channel("vga_blue", vga_blue, {exp_c[1:0], 6'd0}, errs);
	endtask

	// scan-out held idle
	task automatic check_idle_outputs();
		check_flag("vga_hsync", vga_hsync, 1'b1, err_reset);
		check_flag("vga_vsync", vga_vsync, 1'b1, err_reset);
		check_flag("vga_blank_n", vga_blank_n, 1'b0, err_reset);
		check_rgb(8'h00, err_reset);
	endtask

	task automatic report_test(input string name, input int errs);
		tests_run++;
		if (errs != 0) begin
			tests_failed++;
		end
		$display("[%0t] %s: %0d errors, %s", $time, name, errs, (errs == 0) ? "ok" : "not ok");
	endtask

	//////////////////////////////////////////////////
	// write side stimulus
	//////////////////////////////////////////////////

	task automatic drive_stream();
		int cycles;
		logic taken;
		cycles = 0;
		taken  = 1'b0;
		while (accepted < FRAME_PIXELS && cycles < WRITE_TIMEOUT) begin
			@(negedge M10k_pll);
			cycles++;
			check_idle_outputs();
			check_flag("iter_ready", iter_ready, 1'b1, err_handshake);
			check_flag("frame_done", frame_done, 1'b0, err_handshake);
			// new offer only once the last one went through
			if (taken || !iter_valid) begin
				iter_valid = (($random(seed) & 3) != 0);
				next_count(iter_count);
			end
			taken = iter_valid && iter_ready;
			if (taken) begin
				color_model.push_back(expected_color(iter_count));
				accepted++;
			end
		end
		if (accepted < FRAME_PIXELS) begin
			$display("timeout: only %0d of %0d pixels accepted", accepted, FRAME_PIXELS);
			err_handshake++;
			iter_valid = 1'b0;
			return;
		end
		// last pixel still on the bus until the next edge
		cycles = 0;
		while (!frame_done && cycles < DONE_TIMEOUT) begin
			@(negedge M10k_pll);
			cycles++;
			check_flag("iter_ready", iter_ready, 1'b0, err_handshake);
			if (!frame_done) begin
				check_idle_outputs();
			end
			// one more item held on the bus while the frame closes
			if (cycles == 1) begin
				iter_valid = 1'b1;
				next_count(iter_count);
			end
			if (iter_valid && iter_ready) begin
				accepted++;
			end
		end
		if (!frame_done) begin
			$display("timeout: frame_done did not rise after the last pixel");
			err_handshake++;
		end
		report_test("reset and idle state", err_reset);
		// ready must stay low for good
		for (int i = 0; i < EXTRA_OFFERS; i++) begin
			@(negedge M10k_pll);
			check_flag("iter_ready", iter_ready, 1'b0, err_handshake);
			check_flag("frame_done", frame_done, 1'b1, err_handshake);
			if (iter_valid && iter_ready) begin
				accepted++;
			end
		end
		iter_valid = 1'b0;
		check_count("accepted pixels", accepted, FRAME_PIXELS, err_handshake);
		report_test("back-pressure and completion", err_handshake);
	endtask

	//////////////////////////////////////////////////
	// scan-out monitor
	//////////////////////////////////////////////////

	task automatic watch_video();
		int cycles;
		int n;
		int idx;
		int run;
		int lines;
		int frames;
		int hlow;
		int vlow;
		int last_hfall;
		int last_vfall;
		logic prev_blank;
		logic prev_h;
		logic prev_v;
		pixel_color_t exp_c;
		cycles = 0;
		while (!frame_done && cycles < WRITE_TIMEOUT + DONE_TIMEOUT) begin
			@(negedge M10k_pll);
			cycles++;
		end
		if (!frame_done) begin
			$display("timeout: scan-out never started");
			err_timing++;
			return;
		end
		n = 0;
		run = 0;
		lines = 0;
		frames = 0;
		hlow = 0;
		vlow = 0;
		last_hfall = -1;
		last_vfall = -1;
		prev_blank = 1'b0;
		prev_h = 1'b1;
		prev_v = 1'b1;
		cycles = 0;
		while (frames < 2 && cycles < SCAN_TIMEOUT) begin
			@(negedge M10k_pll);
			cycles++;
			// pixel data, raster order
			if (vga_blank_n) begin
				idx = n % FRAME_PIXELS;
				if (idx >= color_model.size()) begin
					$display("pixel %0d shown but never written", idx);
					err_color++;
				end else begin
					exp_c = color_model[idx];
					if (n < FRAME_PIXELS) begin
						check_rgb(exp_c, err_color);
						if (is_bank_edge(idx)) begin
							check_color("bank edge colour",
								{vga_red[7:5], vga_green[7:5], vga_blue[7:6]}, exp_c, err_bank);
							$display("bank edge pixel %0d in bank %0d checked", idx, idx / BANK_WORDS);
						end
					end else begin
						check_rgb(exp_c, err_frame2);
					end
				end
				n++;
				run++;
				if (n == FRAME_PIXELS) begin
					report_test("colour mapping, first frame", err_color);
					report_test("bank boundaries", err_bank);
				end
			end else if (prev_blank) begin
				check_count("active pixels in line", run, H_ACTIVE_PIXELS, err_timing);
				run = 0;
				lines++;
			end
			// hsync width and line period
			if (prev_h && !vga_hsync) begin
				if (last_hfall >= 0) begin
					check_count("line period", cycles - last_hfall, LINE_CYCLES, err_timing);
				end
				last_hfall = cycles;
				hlow = 0;
			end
			if (!vga_hsync) begin
				hlow++;
			end else if (!prev_h) begin
				check_count("hsync pulse width", hlow, H_PULSE_LEN, err_timing);
			end
			// vsync width, frame period, active lines
			if (prev_v && !vga_vsync) begin
				check_count("active lines in frame", lines, V_ACTIVE_LINES, err_timing);
				if (last_vfall >= 0) begin
					check_count("frame period", cycles - last_vfall, FRAME_CYCLES, err_timing);
				end
				last_vfall = cycles;
				lines = 0;
				vlow = 0;
			end
			if (!vga_vsync) begin
				vlow++;
			end else if (!prev_v) begin
				check_count("vsync pulse width", vlow, V_PULSE_LEN * LINE_CYCLES, err_timing);
				frames++;
			end
			prev_blank = vga_blank_n;
			prev_h = vga_hsync;
			prev_v = vga_vsync;
		end
		if (frames < 2) begin
			$display("timeout: only %0d frames scanned out", frames);
			err_timing++;
		end
		check_count("pixels over two frames", n, 2 * FRAME_PIXELS, err_frame2);
		report_test("scan timing", err_timing);
		report_test("second frame repeat", err_frame2);
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		seed = SEED;
		accepted = 0;
		err_reset = 0;
		err_handshake = 0;
		err_color = 0;
		err_bank = 0;
		err_timing = 0;
		err_frame2 = 0;
		tests_run = 0;
		tests_failed = 0;
		reset = 1'b1;
		max_iterations = MAX_ITER;
		iter_count = '0;
		iter_valid = 1'b0;
		repeat (RESET_CYCLES) @(negedge M10k_pll);
		reset = 1'b0;
		fork
			drive_stream();
			watch_video();
		join
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			err_reset + err_handshake + err_color + err_bank + err_timing + err_frame2);
		if (tests_failed == 0 && tests_run == 6) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* sim/fractal_frame_checker.sv */
module fractal_frame_checker (
	input logic                     M10k_pll,
	input logic                     reset,
	input logic                     iter_ready,
	input logic                     frame_done,
	input fractal_pkg::vga_channel_t vga_red,
	input fractal_pkg::vga_channel_t vga_green,
	input fractal_pkg::vga_channel_t vga_blue,
	input logic                     vga_hsync,
	input logic                     vga_vsync,
	input logic                     vga_blank_n
);

	timeunit 1ns;
	timeprecision 100ps;

	//////////////////////////////////////////////////
	// video and handshake rules
	//////////////////////////////////////////////////

	// visible pixels only between sync pulses
	a_blank_inside_sync: assert property (@(posedge M10k_pll) disable iff (reset)
		vga_blank_n |-> (vga_hsync && vga_vsync))
		else $error("blank_n high during a sync pulse");

	// blanked video is black
	a_blank_black: assert property (@(posedge M10k_pll) disable iff (reset)
		!vga_blank_n |-> (vga_red == '0 && vga_green == '0 && vga_blue == '0))
		else $error("nonzero rgb while blanked");

	// one frame per reset
	a_ready_after_done: assert property (@(posedge M10k_pll) disable iff (reset)
		frame_done |-> !iter_ready)
		else $error("iter_ready high after frame_done");

endmodule

bind fractal_frame_top fractal_frame_checker i_checker (
	.M10k_pll    (M10k_pll),
	.reset       (reset),
	.iter_ready  (iter_ready),
	.frame_done  (frame_done),
	.vga_red     (vga_red),
	.vga_green   (vga_green),
	.vga_blue    (vga_blue),
	.vga_hsync   (vga_hsync),
	.vga_vsync   (vga_vsync),
	.vga_blank_n (vga_blank_n)
);

/* hdl/fractal_frame_top.sv */
module fractal_frame_top (
	input  logic                     M10k_pll,
	input  logic                     reset,
	input  fractal_pkg::iter_count_t  max_iterations,
	input  fractal_pkg::iter_count_t  iter_count,
	input  logic                     iter_valid,
	output logic                     iter_ready,
	output logic                     frame_done,
	output fractal_pkg::vga_channel_t vga_red,
	output fractal_pkg::vga_channel_t vga_green,
	output fractal_pkg::vga_channel_t vga_blue,
	output logic                     vga_hsync,
	output logic                     vga_vsync,
	output logic                     vga_blank_n
);

	import fractal_pkg::*;

	// write side
	pixel_color_t pixel_color;
	logic         pixel_valid;
	bank_sel_t    wr_bank;
	bank_addr_t   wr_offset;
	logic         frame_full;

	// read side
	coord_t       next_x;
	coord_t       next_y;
	logic         scan_active;
	pixel_addr_t  rd_addr;
	pixel_color_t rd_color;

	//////////////////////////////////////////////////
	// write path
	//////////////////////////////////////////////////

	iter_color_map i_color_map (
		.M10k_pll       (M10k_pll),
		.reset          (reset),
		.max_iterations (max_iterations),
		.iter_count     (iter_count),
		.iter_valid     (iter_valid),
		.frame_full     (frame_full),
		.iter_ready     (iter_ready),
		.pixel_color    (pixel_color),
		.pixel_valid    (pixel_valid)
	);

	frame_write_counter i_write_counter (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.pixel_valid (pixel_valid),
		.wr_bank     (wr_bank),
		.wr_offset   (wr_offset),
		.frame_full  (frame_full),
		.frame_done  (frame_done)
	);

	frame_memory i_memory (
		.M10k_pll    (M10k_pll),
		.pixel_valid (pixel_valid),
		.pixel_color (pixel_color),
		.wr_bank     (wr_bank),
		.wr_offset   (wr_offset),
		.rd_addr     (rd_addr),
		.rd_color    (rd_color)
	);

	//////////////////////////////////////////////////
	// scan-out path
	//////////////////////////////////////////////////

	// starts once the frame is complete
	scan_timing_fsm i_scan_timing (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.frame_done  (frame_done),
		.next_x      (next_x),
		.next_y      (next_y),
		.scan_active (scan_active),
		.hsync       (vga_hsync),
		.vsync       (vga_vsync)
	);

	video_output i_video_output (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.next_x      (next_x),
		.next_y      (next_y),
		.scan_active (scan_active),
		.rd_color    (rd_color),
		.rd_addr     (rd_addr),
		.vga_red     (vga_red),
		.vga_green   (vga_green),
		.vga_blue    (vga_blue),
		.vga_blank_n (vga_blank_n)
	);

endmodule

/* hdl/video_output.sv */
module video_output (
	input  logic                     M10k_pll,
	input  logic                     reset,
	input  fractal_pkg::coord_t       next_x,
	input  fractal_pkg::coord_t       next_y,
	input  logic                     scan_active,
	input  fractal_pkg::pixel_color_t rd_color,
	output fractal_pkg::pixel_addr_t  rd_addr,
	output fractal_pkg::vga_channel_t vga_red,
	output fractal_pkg::vga_channel_t vga_green,
	output fractal_pkg::vga_channel_t vga_blue,
	output logic                     vga_blank_n
);

	import fractal_pkg::*;

	// active, lined up with rd_color
	logic active_d;

	// raster index of the coordinate
	assign rd_addr = pixel_addr_t'(next_y) * pixel_addr_t'(H_ACTIVE_PIXELS)
		+ pixel_addr_t'(next_x);

	//////////////////////////////////////////////////
	// colour expand and blank
	//////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			active_d    <= 1'b0;
			vga_red     <= '0;
			vga_green   <= '0;
			vga_blue    <= '0;
			vga_blank_n <= 1'b0;
		end else begin
			// memory read takes one cycle
			active_d    <= scan_active;
			vga_blank_n <= active_d;
			// top bits carry the colour, rest zero
			if (active_d) begin
				vga_red   <= {rd_color[7:5], 5'd0};
				vga_green <= {rd_color[4:2], 5'd0};
				vga_blue  <= {rd_color[1:0], 6'd0};
			end else begin
				vga_red   <= '0;
				vga_green <= '0;
				vga_blue  <= '0;
			end
		end
	end

endmodule

/* hdl/scan_timing_fsm.sv */
module scan_timing_fsm (
	input  logic               M10k_pll,
	input  logic               reset,
	input  logic               frame_done,
	output fractal_pkg::coord_t next_x,
	output fractal_pkg::coord_t next_y,
	output logic               scan_active,
	output logic               hsync,
	output logic               vsync
);

	import fractal_pkg::*;

	scan_state_t h_state;
	scan_state_t v_state;
	coord_t      h_count;
	coord_t      v_count;
	// terminal count of the current state
	coord_t      h_last;
	coord_t      v_last;
	// one cycle before back porch ends
	logic        line_done;
	logic        idle;

	// common state order for both machines
	function automatic scan_state_t next_scan_state(input scan_state_t s);
		case (s)
			SCAN_ACTIVE: next_scan_state = SCAN_FRONT;
			SCAN_FRONT:  next_scan_state = SCAN_PULSE;
			SCAN_PULSE:  next_scan_state = SCAN_BACK;
			default:     next_scan_state = SCAN_ACTIVE;
		endcase
	endfunction

	// hold everything until the frame is in memory
	assign idle = reset | ~frame_done;

	// state lengths, minus one
	always_comb begin
		case (h_state)
			SCAN_ACTIVE: h_last = coord_t'(H_ACTIVE_PIXELS - 1);
			SCAN_FRONT:  h_last = coord_t'(H_FRONT_LEN - 1);
			SCAN_PULSE:  h_last = coord_t'(H_PULSE_LEN - 1);
			default:     h_last = coord_t'(H_BACK_LEN - 1);
		endcase
		case (v_state)
			SCAN_ACTIVE: v_last = coord_t'(V_ACTIVE_LINES - 1);
			SCAN_FRONT:  v_last = coord_t'(V_FRONT_LEN - 1);
			SCAN_PULSE:  v_last = coord_t'(V_PULSE_LEN - 1);
			default:     v_last = coord_t'(V_BACK_LEN - 1);
		endcase
	end

	//////////////////////////////////////////////////
	// horizontal, counts cycles
	//////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (idle) begin
			h_state   <= SCAN_ACTIVE;
			h_count   <= '0;
			line_done <= 1'b0;
			hsync     <= 1'b1;
		end else begin
			if (h_count == h_last) begin
				h_count <= '0;
				h_state <= next_scan_state(h_state);
			end else begin
				h_count <= h_count + 1'b1;
			end
			// early by one so v moves with h back to active
			line_done <= (h_state == SCAN_BACK) && (h_count == coord_t'(H_BACK_LEN - 2));
			// sync low through the pulse state
			hsync <= (h_state != SCAN_PULSE);
		end
	end

	//////////////////////////////////////////////////
	// vertical, counts lines
	//////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (idle) begin
			v_state <= SCAN_ACTIVE;
			v_count <= '0;
			vsync   <= 1'b1;
		end else begin
			// only step at line ends
			if (line_done) begin
				if (v_count == v_last) begin
					v_count <= '0;
					v_state <= next_scan_state(v_state);
				end else begin
					v_count <= v_count + 1'b1;
				end
			end
			vsync <= (v_state != SCAN_PULSE);
		end
	end

	// coordinate for the next pixel, zero outside the window
	assign next_x      = (h_state == SCAN_ACTIVE) ? h_count : '0;
	assign next_y      = (v_state == SCAN_ACTIVE) ? v_count : '0;
	assign scan_active = frame_done && (h_state == SCAN_ACTIVE) && (v_state == SCAN_ACTIVE);

endmodule

/* hdl/frame_memory.sv */
module frame_memory (
	input  logic                     M10k_pll,
	input  logic                     pixel_valid,
	input  fractal_pkg::pixel_color_t pixel_color,
	input  fractal_pkg::bank_sel_t    wr_bank,
	input  fractal_pkg::bank_addr_t   wr_offset,
	input  fractal_pkg::pixel_addr_t  rd_addr,
	output fractal_pkg::pixel_color_t rd_color
);

	import fractal_pkg::*;

	// one array per bank
	pixel_color_t mem [NUM_BANKS][BANK_WORDS];
	// per bank read data
	pixel_color_t bank_q [NUM_BANKS];

	bank_sel_t  rd_bank;
	bank_sel_t  rd_bank_q;
	bank_addr_t rd_offset;

	//////////////////////////////////////////////////
	// read decode
	//////////////////////////////////////////////////

	// bank bases are multiples of BANK_WORDS
	always_comb begin
		rd_bank = '0;
		for (int b = 1; b < NUM_BANKS; b++) begin
			if (rd_addr >= pixel_addr_t'(b * BANK_WORDS)) begin
				rd_bank = bank_sel_t'(b);
			end
		end
		rd_offset = bank_addr_t'(rd_addr - pixel_addr_t'(rd_bank) * pixel_addr_t'(BANK_WORDS));
	end

	//////////////////////////////////////////////////
	// banks
	//////////////////////////////////////////////////

	// write the addressed bank, read all banks at the same offset
	always_ff @(posedge M10k_pll) begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (pixel_valid && (wr_bank == bank_sel_t'(b))) begin
				mem[b][wr_offset] <= pixel_color;
			end
			bank_q[b] <= mem[b][rd_offset];
		end
		rd_bank_q <= rd_bank;
	end

	// mux with the bank number that matches the data
	assign rd_color = bank_q[rd_bank_q];

endmodule

/* hdl/frame_write_counter.sv */
module frame_write_counter (
	input  logic                   M10k_pll,
	input  logic                   reset,
	input  logic                   pixel_valid,
	output fractal_pkg::bank_sel_t  wr_bank,
	output fractal_pkg::bank_addr_t wr_offset,
	output logic                   frame_full,
	output logic                   frame_done
);

	import fractal_pkg::*;

	logic bank_end;
	logic last_word;

	// last word of the current bank
	assign bank_end = (wr_offset == bank_addr_t'(BANK_WORDS - 1));

	// final pixel of the frame being written now
	assign last_word = pixel_valid && bank_end && (wr_bank == bank_sel_t'(NUM_BANKS - 1));

	// full while the last write is in flight and after
	assign frame_full = frame_done | last_word;

	//////////////////////////////////////////////////
	// write position
	//////////////////////////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			wr_bank    <= '0;
			wr_offset  <= '0;
			frame_done <= 1'b0;
		end else begin
			if (pixel_valid) begin
				// wrap offset, step to next bank
				if (bank_end) begin
					wr_offset <= '0;
					wr_bank   <= wr_bank + 1'b1;
				end else begin
					wr_offset <= wr_offset + 1'b1;
				end
			end
			// sticky until reset
			if (last_word) begin
				frame_done <= 1'b1;
			end
		end
	end

endmodule

/* hdl/iter_color_map.sv */
module iter_color_map (
	input  logic                    M10k_pll,
	input  logic                    reset,
	input  fractal_pkg::iter_count_t max_iterations,
	input  fractal_pkg::iter_count_t iter_count,
	input  logic                    iter_valid,
	input  logic                    frame_full,
	output logic                    iter_ready,
	output fractal_pkg::pixel_color_t pixel_color,
	output logic                    pixel_valid
);

	import fractal_pkg::*;

	// band index into the palette
	logic [3:0] band;
	logic       accept;

	//////////////////////////////////////////////////
	// input handshake
	//////////////////////////////////////////////////

	// stop taking counts once the frame is full
	assign iter_ready = ~frame_full;
	assign accept     = iter_valid & iter_ready;

	//////////////////////////////////////////////////
	// band select
	//////////////////////////////////////////////////

	// default is the lowest band
	// walk thresholds from smallest up so the largest hit wins
	always_comb begin
		band = 4'(PALETTE_BANDS - 1);
		for (int k = PALETTE_BANDS - 2; k >= 0; k--) begin
			if (iter_count >= (max_iterations >> k)) begin
				band = 4'(k);
			end
		end
	end

	//////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////

	// valid follows the accept, one write per accepted count
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			pixel_valid <= 1'b0;
		end else begin
			pixel_valid <= accept;
		end
	end

	// colour payload only loads on accept
	always_ff @(posedge M10k_pll) begin
		if (accept) begin
			pixel_color <= PALETTE[band];
		end
	end

endmodule

/* hdl/fractal_pkg.sv */
package fractal_pkg;

	//////////////////////////////////////////////////
	// design types
	//////////////////////////////////////////////////

	// iteration count, also the runtime maximum
	typedef logic [31:0] iter_count_t;
	// stored pixel, rrr_ggg_bb
	typedef logic [7:0] pixel_color_t;
	// one expanded vga channel
	typedef logic [7:0] vga_channel_t;
	// screen x or y
	typedef logic [9:0] coord_t;
	// raster index y*640 + x
	typedef logic [18:0] pixel_addr_t;
	typedef logic [1:0] bank_sel_t;
	typedef logic [16:0] bank_addr_t;

	// shared by the horizontal and vertical machines
	typedef enum logic [1:0] {
		SCAN_ACTIVE,
		SCAN_FRONT,
		SCAN_PULSE,
		SCAN_BACK
	} scan_state_t;

	//////////////////////////////////////////////////
	// frame geometry and vga timing
	//////////////////////////////////////////////////

	localparam int H_ACTIVE_PIXELS = 640;
	localparam int V_ACTIVE_LINES  = 480;
	// horizontal, in cycles
	localparam int H_FRONT_LEN = 16;
	localparam int H_PULSE_LEN = 96;
	localparam int H_BACK_LEN  = 48;
	// vertical, in lines
	localparam int V_FRONT_LEN = 10;
	localparam int V_PULSE_LEN = 2;
	localparam int V_BACK_LEN  = 33;

	// frame split into equal banks
	localparam int FRAME_PIXELS = H_ACTIVE_PIXELS * V_ACTIVE_LINES;
	localparam int NUM_BANKS    = 4;
	localparam int BANK_WORDS   = FRAME_PIXELS / NUM_BANKS;

	//////////////////////////////////////////////////
	// palette, band k means count >= max >> k
	//////////////////////////////////////////////////

	localparam int PALETTE_BANDS = 10;
	localparam pixel_color_t PALETTE [PALETTE_BANDS] = '{
		8'b000_000_00, 8'b011_001_00, 8'b011_001_00, 8'b101_010_01, 8'b011_001_01,
		8'b001_001_01, 8'b011_010_10, 8'b010_100_10, 8'b010_100_10, 8'b010_100_10
	};

endpackage
